// File: hdl/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// instruction memory word address width.
`define CORE_IMEM_AW 8

// data memory word address width.
`define CORE_DMEM_AW 8

`define CORE_RESET_PC 32'h0000_0000

`endif

// File: hdl/core_pkg.sv
package core_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [4:0]  alu_op_t;

	typedef enum logic [1:0] {
		WB_ALU = 2'd0,
		WB_MEM = 2'd1,
		WB_PC4 = 2'd2
	} wb_sel_e;

	localparam opcode_t OP_RTYPE = 6'h00;
	localparam opcode_t OP_JAL   = 6'h03;
	localparam opcode_t OP_BEQ   = 6'h04;
	localparam opcode_t OP_ADDI  = 6'h08;
	localparam opcode_t OP_LW    = 6'h23;
	localparam opcode_t OP_SW    = 6'h2b;
	localparam opcode_t OP_LWA   = 6'h30; // absolute address load.
	localparam opcode_t OP_SWA   = 6'h38;

	localparam logic [5:0] FN_ADD = 6'h20;
	localparam logic [5:0] FN_SUB = 6'h22;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR  = 6'h25;
	localparam logic [5:0] FN_SLT = 6'h2a;

	// zero is left free so a bubble computes nothing.
	localparam alu_op_t ALU_ADD = 5'd1;
	localparam alu_op_t ALU_SUB = 5'd2;
	localparam alu_op_t ALU_AND = 5'd3;
	localparam alu_op_t ALU_OR  = 5'd4;
	localparam alu_op_t ALU_SLT = 5'd5;

endpackage

// File: hdl/decode_ctrl_if.sv
`timescale 1ns/100ps

interface decode_ctrl_if import core_pkg::*; ();
	logic    do_dm_read;
	logic    do_dm_write;
	logic    do_reg_write;
	logic    select_mem_addr; // immediate as memory address.
	wb_sel_e select_write_reg;
	logic    alu_src2_imm;
	opcode_t opcode;
	alu_op_t sub_op_base;

	modport decoder (
		output do_dm_read, do_dm_write, do_reg_write, select_mem_addr,
		output select_write_reg, alu_src2_imm, opcode, sub_op_base
	);

	modport walls (
		input do_dm_read, do_dm_write, do_reg_write, select_mem_addr,
		input select_write_reg, alu_src2_imm, opcode, sub_op_base
	);
endinterface

// File: hdl/fetch_unit.sv
`timescale 1ns/100ps
`include "core_settings.svh"

module fetch_unit import core_pkg::*; (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     enable,
	input  logic                     hold,
	input  logic                     redirect,
	input  word_t                    redirect_pc,
	input  logic                     imem_write,
	input  logic [`CORE_IMEM_AW-1:0] imem_addr,
	input  word_t                    imem_data,
	output word_t                    instruction,
	output word_t                    current_pc
);
	word_t imem [2**`CORE_IMEM_AW];

	always_ff @(posedge clock) begin
		if (reset) begin
			current_pc <= `CORE_RESET_PC;
		end else if (enable && !hold) begin
			current_pc <= redirect ? redirect_pc : current_pc + 32'd4;
		end
	end

	// program load only while the core is stopped.
	always_ff @(posedge clock) begin
		if (imem_write && !enable) begin
			imem[imem_addr] <= imem_data;
		end
	end

	assign instruction = imem[current_pc[`CORE_IMEM_AW+1:2]]; // word index.

endmodule

// File: hdl/instr_decoder.sv
`timescale 1ns/100ps

module instr_decoder import core_pkg::*; (
	input  word_t               instruction,
	input  word_t               current_pc,
	input  word_t               ra_data,
	input  word_t               rt_data,
	decode_ctrl_if.decoder      ctrl,
	output reg_addr_t           ra_addr,
	output reg_addr_t           rt_addr,
	output reg_addr_t           write_reg_addr,
	output word_t               imm_extend,
	output logic                redirect,
	output word_t               redirect_pc
);
	opcode_t    op;
	logic [5:0] funct;
	word_t      pc_plus4;

	assign op         = instruction[31:26];
	assign funct      = instruction[5:0];
	assign ra_addr    = instruction[25:21];
	assign rt_addr    = instruction[20:16];
	assign imm_extend = {{16{instruction[15]}}, instruction[15:0]};
	assign pc_plus4   = current_pc + 32'd4;

	always_comb begin
		ctrl.do_dm_read       = 1'b0;
		ctrl.do_dm_write      = 1'b0;
		ctrl.do_reg_write     = 1'b0;
		ctrl.select_mem_addr  = 1'b0;
		ctrl.select_write_reg = WB_ALU;
		ctrl.alu_src2_imm     = 1'b0;
		ctrl.opcode           = op;
		ctrl.sub_op_base      = '0;
		write_reg_addr        = '0;
		redirect              = 1'b0;
		redirect_pc           = pc_plus4 + {imm_extend[29:0], 2'b00}; // beq target.
		case (op)
			OP_RTYPE: begin
				write_reg_addr = instruction[15:11];
				ctrl.do_reg_write = 1'b1;
				case (funct)
					FN_ADD:  ctrl.sub_op_base = ALU_ADD;
					FN_SUB:  ctrl.sub_op_base = ALU_SUB;
					FN_AND:  ctrl.sub_op_base = ALU_AND;
					FN_OR:   ctrl.sub_op_base = ALU_OR;
					FN_SLT:  ctrl.sub_op_base = ALU_SLT;
					default: ctrl.do_reg_write = 1'b0; // bubble lands here.
				endcase
			end
			OP_ADDI, OP_LW, OP_LWA: begin
				write_reg_addr        = rt_addr;
				ctrl.do_reg_write     = 1'b1;
				ctrl.alu_src2_imm     = 1'b1;
				ctrl.sub_op_base      = ALU_ADD;
				ctrl.do_dm_read       = (op != OP_ADDI);
				ctrl.select_mem_addr  = (op == OP_LWA);
				ctrl.select_write_reg = (op == OP_ADDI) ? WB_ALU : WB_MEM;
			end
			OP_SW, OP_SWA: begin
				ctrl.do_dm_write     = 1'b1;
				ctrl.alu_src2_imm    = 1'b1;
				ctrl.sub_op_base     = ALU_ADD;
				ctrl.select_mem_addr = (op == OP_SWA);
			end
			OP_BEQ: begin
				redirect = (ra_data == rt_data);
			end
			OP_JAL: begin
				write_reg_addr        = 5'd31;
				ctrl.do_reg_write     = 1'b1;
				ctrl.select_write_reg = WB_PC4;
				redirect              = 1'b1;
				redirect_pc           = {pc_plus4[31:28], instruction[25:0], 2'b00};
			end
			default: ;
		endcase
	end

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/100ps

module reg_file import core_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  reg_addr_t ra_addr,
	input  reg_addr_t rt_addr,
	output word_t     ra_data,
	output word_t     rt_data,
	input  logic      do_reg_write,
	input  reg_addr_t write_reg_addr,
	input  word_t     write_reg_data
);
	word_t regs [32];
	logic  write_live;

	assign write_live = do_reg_write && (write_reg_addr != '0); // r0 stays zero.

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (write_live) begin
			regs[write_reg_addr] <= write_reg_data;
		end
	end

	// same-cycle write is seen by decode.
	always_comb begin
		ra_data = (write_live && ra_addr == write_reg_addr) ? write_reg_data : regs[ra_addr];
		rt_data = (write_live && rt_addr == write_reg_addr) ? write_reg_data : regs[rt_addr];
	end

endmodule

// File: hdl/alu.sv
`timescale 1ns/100ps

module alu import core_pkg::*; (
	input  alu_op_t sub_op_base,
	input  word_t   src1,
	input  word_t   src2,
	output word_t   result
);

	always_comb begin
		case (sub_op_base)
			ALU_ADD: result = src1 + src2;
			ALU_SUB: result = src1 - src2;
			ALU_AND: result = src1 & src2;
			ALU_OR:  result = src1 | src2;
			ALU_SLT: result = {31'b0, $signed(src1) < $signed(src2)}; // signed compare.
			default: result = '0;
		endcase
	end

endmodule

// File: hdl/interlock_unit.sv
`timescale 1ns/100ps

module interlock_unit import core_pkg::*; (
	input  reg_addr_t ra_addr,
	input  reg_addr_t rt_addr,
	input  logic      uses_rt,
	input  reg_addr_t ex_write_reg_addr,
	input  reg_addr_t mem_write_reg_addr,
	input  logic      ex_do_reg_write,
	input  logic      mem_do_reg_write,
	input  logic      redirect,
	output logic      do_hazard,
	output logic      do_flush_REG1
);
	logic ra_busy;
	logic rt_busy;

	// write-back stage is covered by the register file bypass.
	always_comb begin
		ra_busy = (ra_addr != '0) &&
			((ex_do_reg_write && ra_addr == ex_write_reg_addr) ||
			 (mem_do_reg_write && ra_addr == mem_write_reg_addr));
		rt_busy = uses_rt && (rt_addr != '0) &&
			((ex_do_reg_write && rt_addr == ex_write_reg_addr) ||
			 (mem_do_reg_write && rt_addr == mem_write_reg_addr));
	end

	assign do_hazard     = ra_busy || rt_busy;
	assign do_flush_REG1 = redirect && !do_hazard; // stalled branch waits for operands.

endmodule

// File: hdl/regwalls.sv
`timescale 1ns/100ps

module regwalls import core_pkg::*; (
	input  logic         clock,
	input  logic         reset,
	input  logic         enable_regwalls,
	input  logic         do_hazard,
	input  logic         do_flush_REG1,
	decode_ctrl_if.walls ctrl,

	input  word_t        iREG1_instruction,
	output word_t        oREG1_instruction,

	input  word_t        iREG2_reg_ra_data,
	output word_t        mREG2_reg_ra_data,
	output word_t        oREG3_reg_ra_data,
	input  word_t        iREG2_reg_rt_data,
	output word_t        oREG3_reg_rt_data,

	input  reg_addr_t    iREG2_write_reg_addr,
	output reg_addr_t    mREG2_write_reg_addr,
	output reg_addr_t    mREG3_write_reg_addr,
	output reg_addr_t    oREG4_write_reg_addr,

	output opcode_t      oREG2_opcode,
	output alu_op_t      oREG2_sub_op_base,

	output logic         oREG3_select_mem_addr,
	output wb_sel_e      mREG2_select_write_reg,
	output wb_sel_e      oREG3_select_write_reg,

	output logic         mREG2_do_dm_read,
	output logic         mREG2_do_reg_write,
	output logic         mREG3_do_reg_write,
	output logic         oREG3_do_dm_read,
	output logic         oREG3_do_dm_write,
	output logic         oREG4_do_reg_write,

	input  word_t        iREG2_alu_src2,
	output word_t        oREG2_alu_src2,
	input  word_t        iREG2_imm_extend,
	output word_t        mREG2_imm_extend,
	output word_t        oREG3_imm_extend,

	input  word_t        iREG3_alu_result,
	output word_t        oREG3_alu_result,

	input  word_t        iREG4_write_reg_data,
	output word_t        oREG4_write_reg_data,

	input  word_t        iREG2_current_pc,
	output word_t        oREG3_current_pc
);
	word_t mREG2_reg_rt_data;
	word_t mREG2_current_pc;
	logic  mREG2_select_mem_addr;
	logic  mREG2_do_dm_write;

	// control state, REG1 included.
	always_ff @(posedge clock) begin
		if (reset) begin
			oREG1_instruction      <= '0;
			oREG2_opcode           <= '0;
			oREG2_sub_op_base      <= '0;
			mREG2_do_dm_read       <= 1'b0;
			mREG2_do_dm_write      <= 1'b0;
			mREG2_do_reg_write     <= 1'b0;
			mREG2_write_reg_addr   <= '0;
			mREG2_select_mem_addr  <= 1'b0;
			mREG2_select_write_reg <= WB_ALU;
			oREG3_do_dm_read       <= 1'b0;
			oREG3_do_dm_write      <= 1'b0;
			mREG3_do_reg_write     <= 1'b0;
			mREG3_write_reg_addr   <= '0;
			oREG3_select_mem_addr  <= 1'b0;
			oREG3_select_write_reg <= WB_ALU;
			oREG4_do_reg_write     <= 1'b0;
			oREG4_write_reg_addr   <= '0;
		end else if (enable_regwalls) begin
			if (do_hazard) begin
				oREG1_instruction <= oREG1_instruction; // hold for re-decode.
			end else if (do_flush_REG1) begin
				oREG1_instruction <= '0;
			end else begin
				oREG1_instruction <= iREG1_instruction;
			end

			if (do_hazard) begin
				oREG2_opcode           <= '0;
				oREG2_sub_op_base      <= '0;
				mREG2_do_dm_read       <= 1'b0;
				mREG2_do_dm_write      <= 1'b0;
				mREG2_do_reg_write     <= 1'b0;
				mREG2_write_reg_addr   <= '0;
				mREG2_select_mem_addr  <= 1'b0;
				mREG2_select_write_reg <= WB_ALU;
			end else begin
				oREG2_opcode           <= ctrl.opcode;
				oREG2_sub_op_base      <= ctrl.sub_op_base;
				mREG2_do_dm_read       <= ctrl.do_dm_read;
				mREG2_do_dm_write      <= ctrl.do_dm_write;
				mREG2_do_reg_write     <= ctrl.do_reg_write;
				mREG2_write_reg_addr   <= iREG2_write_reg_addr;
				mREG2_select_mem_addr  <= ctrl.select_mem_addr;
				mREG2_select_write_reg <= ctrl.select_write_reg;
			end

			oREG3_do_dm_read       <= mREG2_do_dm_read;
			oREG3_do_dm_write      <= mREG2_do_dm_write;
			mREG3_do_reg_write     <= mREG2_do_reg_write;
			mREG3_write_reg_addr   <= mREG2_write_reg_addr;
			oREG3_select_mem_addr  <= mREG2_select_mem_addr;
			oREG3_select_write_reg <= mREG2_select_write_reg;

			oREG4_do_reg_write   <= mREG3_do_reg_write;
			oREG4_write_reg_addr <= mREG3_write_reg_addr;
		end
	end

	// data fields.
	always_ff @(posedge clock) begin
		if (enable_regwalls) begin
			if (do_hazard) begin
				mREG2_reg_ra_data <= '0;
				mREG2_reg_rt_data <= '0;
				oREG2_alu_src2    <= '0;
				mREG2_imm_extend  <= '0;
				mREG2_current_pc  <= '0;
			end else begin
				mREG2_reg_ra_data <= iREG2_reg_ra_data;
				mREG2_reg_rt_data <= iREG2_reg_rt_data;
				oREG2_alu_src2    <= ctrl.alu_src2_imm ? iREG2_imm_extend : iREG2_alu_src2;
				mREG2_imm_extend  <= iREG2_imm_extend;
				mREG2_current_pc  <= iREG2_current_pc;
			end

			oREG3_reg_ra_data <= mREG2_reg_ra_data;
			oREG3_reg_rt_data <= mREG2_reg_rt_data;
			oREG3_alu_result  <= iREG3_alu_result;
			oREG3_imm_extend  <= mREG2_imm_extend;
			oREG3_current_pc  <= mREG2_current_pc;

			oREG4_write_reg_data <= iREG4_write_reg_data;
		end
	end

endmodule

// File: hdl/data_mem.sv
`timescale 1ns/100ps
`include "core_settings.svh"

module data_mem import core_pkg::*; (
	input  logic                     clock,
	input  logic [`CORE_DMEM_AW-1:0] address,
	input  logic                     do_dm_write,
	input  word_t                    write_data,
	output word_t                    read_data
);
	word_t mem [2**`CORE_DMEM_AW];

	always_ff @(posedge clock) begin
		if (do_dm_write) begin
			mem[address] <= write_data;
		end
	end

	assign read_data = mem[address]; // combinational read.

endmodule

// File: hdl/core_top.sv
`timescale 1ns/100ps
`include "core_settings.svh"

module core_top import core_pkg::*; (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     run,
	input  logic                     imem_write,
	input  logic [`CORE_IMEM_AW-1:0] imem_addr,
	input  word_t                    imem_data,
	output logic                     wb_valid,
	output reg_addr_t                wb_addr,
	output word_t                    wb_data
);
	word_t     fetch_instruction;
	word_t     fetch_pc;
	word_t     decode_pc;
	word_t     decode_instruction;
	reg_addr_t ra_addr;
	reg_addr_t rt_addr;
	word_t     ra_data;
	word_t     rt_data;
	reg_addr_t dec_write_reg_addr;
	word_t     imm_extend;
	logic      redirect;
	word_t     redirect_pc;
	logic      uses_rt;
	logic      do_hazard;
	logic      do_flush_REG1;
	word_t     ex_ra_data;
	word_t     ex_src2;
	alu_op_t   ex_sub_op;
	reg_addr_t ex_write_reg_addr;
	logic      ex_do_reg_write;
	word_t     alu_result;
	word_t     mem_rt_data;
	word_t     mem_alu_result;
	word_t     mem_imm;
	word_t     mem_pc;
	word_t     mem_addr;
	logic      mem_select_mem_addr;
	wb_sel_e   mem_select_write_reg;
	logic      mem_do_dm_write;
	reg_addr_t mem_write_reg_addr;
	logic      mem_do_reg_write;
	word_t     dm_read_data;
	word_t     wb_sel_data;
	logic      wb_do_reg_write;

	decode_ctrl_if dec_ctrl ();

	fetch_unit fetch_inst (
		.clock(clock), .reset(reset), .enable(run), .hold(do_hazard),
		.redirect(redirect), .redirect_pc(redirect_pc),
		.imem_write(imem_write), .imem_addr(imem_addr), .imem_data(imem_data),
		.instruction(fetch_instruction), .current_pc(fetch_pc)
	);

	assign decode_pc = fetch_pc - 32'd4; // REG1 instruction trails the PC by one word.

	instr_decoder decoder_inst (
		.instruction(decode_instruction), .current_pc(decode_pc),
		.ra_data(ra_data), .rt_data(rt_data), .ctrl(dec_ctrl),
		.ra_addr(ra_addr), .rt_addr(rt_addr), .write_reg_addr(dec_write_reg_addr),
		.imm_extend(imm_extend), .redirect(redirect), .redirect_pc(redirect_pc)
	);

	reg_file reg_file_inst (
		.clock(clock), .reset(reset),
		.ra_addr(ra_addr), .rt_addr(rt_addr), .ra_data(ra_data), .rt_data(rt_data),
		.do_reg_write(wb_valid), .write_reg_addr(wb_addr), .write_reg_data(wb_data)
	);

	assign uses_rt = dec_ctrl.opcode inside {OP_RTYPE, OP_SW, OP_SWA, OP_BEQ};

	interlock_unit interlock_inst (
		.ra_addr(ra_addr), .rt_addr(rt_addr), .uses_rt(uses_rt),
		.ex_write_reg_addr(ex_write_reg_addr), .mem_write_reg_addr(mem_write_reg_addr),
		.ex_do_reg_write(ex_do_reg_write), .mem_do_reg_write(mem_do_reg_write),
		.redirect(redirect), .do_hazard(do_hazard), .do_flush_REG1(do_flush_REG1)
	);

	regwalls regwalls_inst (
		.clock(clock), .reset(reset), .enable_regwalls(run),
		.do_hazard(do_hazard), .do_flush_REG1(do_flush_REG1), .ctrl(dec_ctrl),
		.iREG1_instruction(fetch_instruction), .oREG1_instruction(decode_instruction),
		.iREG2_reg_ra_data(ra_data), .mREG2_reg_ra_data(ex_ra_data),
		.oREG3_reg_ra_data(),
		.iREG2_reg_rt_data(rt_data), .oREG3_reg_rt_data(mem_rt_data),
		.iREG2_write_reg_addr(dec_write_reg_addr), .mREG2_write_reg_addr(ex_write_reg_addr),
		.mREG3_write_reg_addr(mem_write_reg_addr), .oREG4_write_reg_addr(wb_addr),
		.oREG2_opcode(), .oREG2_sub_op_base(ex_sub_op),
		.oREG3_select_mem_addr(mem_select_mem_addr),
		.mREG2_select_write_reg(), .oREG3_select_write_reg(mem_select_write_reg),
		.mREG2_do_dm_read(), .mREG2_do_reg_write(ex_do_reg_write),
		.mREG3_do_reg_write(mem_do_reg_write), .oREG3_do_dm_read(),
		.oREG3_do_dm_write(mem_do_dm_write), .oREG4_do_reg_write(wb_do_reg_write),
		.iREG2_alu_src2(rt_data), .oREG2_alu_src2(ex_src2),
		.iREG2_imm_extend(imm_extend), .mREG2_imm_extend(), .oREG3_imm_extend(mem_imm),
		.iREG3_alu_result(alu_result), .oREG3_alu_result(mem_alu_result),
		.iREG4_write_reg_data(wb_sel_data), .oREG4_write_reg_data(wb_data),
		.iREG2_current_pc(decode_pc), .oREG3_current_pc(mem_pc)
	);

	alu alu_inst (
		.sub_op_base(ex_sub_op), .src1(ex_ra_data), .src2(ex_src2), .result(alu_result)
	);

	// lwa and swa take the immediate as a byte address.
	assign mem_addr = mem_select_mem_addr ? mem_imm : mem_alu_result;

	data_mem data_mem_inst (
		.clock(clock), .address(mem_addr[`CORE_DMEM_AW+1:2]),
		.do_dm_write(mem_do_dm_write && run), .write_data(mem_rt_data),
		.read_data(dm_read_data)
	);

	always_comb begin
		case (mem_select_write_reg)
			WB_MEM:  wb_sel_data = dm_read_data;
			WB_PC4:  wb_sel_data = mem_pc + 32'd4; // jal link.
			default: wb_sel_data = mem_alu_result;
		endcase
	end

	assign wb_valid = wb_do_reg_write && run;

endmodule

// File: verif/wb_checker.sv
`timescale 1ns/100ps

module wb_checker import core_pkg::*; #(
	parameter int MAX_EXPECTED = 64
) (
	input  logic      clock,
	input  logic      reset,
	input  logic      wb_valid,
	input  reg_addr_t wb_addr,
	input  word_t     wb_data,
	input  logic      exp_push,
	input  reg_addr_t exp_addr,
	input  word_t     exp_data,
	output int        seen_count,
	output int        mismatch_count,
	output int        extra_count
);
	reg_addr_t exp_addr_list [MAX_EXPECTED];
	word_t     exp_data_list [MAX_EXPECTED];
	int        exp_count;

	always @(posedge clock) begin
		if (reset) begin
			exp_count      <= 0;
			seen_count     <= 0;
			mismatch_count <= 0;
			extra_count    <= 0;
		end else begin
			// expectations arrive only while the core is stopped.
			if (exp_push && exp_count < MAX_EXPECTED) begin
				exp_addr_list[exp_count] <= exp_addr;
				exp_data_list[exp_count] <= exp_data;
				exp_count                <= exp_count + 1;
			end

			if (wb_valid) begin
				seen_count <= seen_count + 1;
				if (seen_count >= exp_count) begin
					extra_count <= extra_count + 1;
					$display("unexpected extra write-back at time %0t: r%0d = %h",
						$time, wb_addr, wb_data);
				end else if (wb_addr !== exp_addr_list[seen_count] ||
						wb_data !== exp_data_list[seen_count]) begin
					mismatch_count <= mismatch_count + 1;
					$display("error at time %0t: write-back %0d expected r%0d = %h, got r%0d = %h",
						$time, seen_count, exp_addr_list[seen_count],
						exp_data_list[seen_count], wb_addr, wb_data);
				end
			end
		end
	end

endmodule

// File: verif/core_top_tb.sv
`timescale 1ns/100ps
`include "core_settings.svh"

module core_top_tb import core_pkg::*; ();
	localparam int MAX_ROWS     = 32;
	localparam int RUN_TIMEOUT  = 500; // cycles.
	localparam int QUIET_CYCLES = 60;

	logic                     clock;
	logic                     reset;
	logic                     run;
	logic                     imem_write;
	logic [`CORE_IMEM_AW-1:0] imem_addr;
	word_t                    imem_data;
	logic                     wb_valid;
	reg_addr_t                wb_addr;
	word_t                    wb_data;

	logic      exp_push;
	reg_addr_t exp_addr;
	word_t     exp_data;
	int        seen_count;
	int        mismatch_count;
	int        extra_count;

	word_t     prog_instr [MAX_ROWS];
	logic      prog_has_wb [MAX_ROWS];
	reg_addr_t prog_wb_reg [MAX_ROWS];
	word_t     prog_wb_val [MAX_ROWS];
	int        row_count;
	int        wb_expected;
	int        missing_count;
	int        cycles;
	logic      timed_out;

	core_top core_top_inst (
		.clock(clock), .reset(reset), .run(run),
		.imem_write(imem_write), .imem_addr(imem_addr), .imem_data(imem_data),
		.wb_valid(wb_valid), .wb_addr(wb_addr), .wb_data(wb_data)
	);

	wb_checker wb_checker_inst (
		.clock(clock), .reset(reset),
		.wb_valid(wb_valid), .wb_addr(wb_addr), .wb_data(wb_data),
		.exp_push(exp_push), .exp_addr(exp_addr), .exp_data(exp_data),
		.seen_count(seen_count), .mismatch_count(mismatch_count), .extra_count(extra_count)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	function automatic word_t rtype_word(int rs, int rt, int rd, logic [5:0] funct);
		return {OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, funct};
	endfunction

	function automatic word_t itype_word(opcode_t op, int rs, int rt, int imm);
		return {op, rs[4:0], rt[4:0], imm[15:0]};
	endfunction

	function automatic word_t jump_word(opcode_t op, int target);
		return {op, target[25:0]};
	endfunction

	task automatic add_row(word_t instr, logic has_wb, int rd, word_t value);
		prog_instr[row_count]  = instr;
		prog_has_wb[row_count] = has_wb;
		prog_wb_reg[row_count] = rd[4:0];
		prog_wb_val[row_count] = value;
		row_count++;
		if (has_wb) begin
			wb_expected++;
		end
	endtask

	task automatic build_program();
		row_count = 0;
		wb_expected = 0;
		add_row(itype_word(OP_ADDI, 0, 1, 5), 1'b1, 1, 32'h0000_0005);
		add_row(itype_word(OP_ADDI, 0, 2, -3), 1'b1, 2, 32'hffff_fffd);
		add_row(rtype_word(1, 2, 3, FN_ADD), 1'b1, 3, 32'h0000_0002);
		add_row(rtype_word(2, 1, 4, FN_SUB), 1'b1, 4, 32'hffff_fff8);
		add_row(rtype_word(1, 2, 5, FN_AND), 1'b1, 5, 32'h0000_0005);
		add_row(rtype_word(1, 2, 6, FN_OR), 1'b1, 6, 32'hffff_fffd);
		add_row(rtype_word(2, 1, 7, FN_SLT), 1'b1, 7, 32'h0000_0001); // -3 < 5.
		add_row(rtype_word(1, 2, 8, FN_SLT), 1'b1, 8, 32'h0000_0000);
		add_row(itype_word(OP_ADDI, 0, 9, 16'h40), 1'b1, 9, 32'h0000_0040);
		add_row(itype_word(OP_SW, 9, 4, 8), 1'b0, 0, 32'h0);
		add_row(itype_word(OP_LW, 9, 10, 8), 1'b1, 10, 32'hffff_fff8);
		add_row(itype_word(OP_LWA, 9, 11, 16'h48), 1'b1, 11, 32'hffff_fff8); // r9 field ignored.
		add_row(itype_word(OP_ADDI, 0, 12, 16'h1234), 1'b1, 12, 32'h0000_1234);
		add_row(itype_word(OP_SWA, 9, 12, 16'h20), 1'b0, 0, 32'h0);
		add_row(itype_word(OP_LW, 0, 13, 16'h20), 1'b1, 13, 32'h0000_1234);
		add_row(rtype_word(13, 13, 14, FN_ADD), 1'b1, 14, 32'h0000_2468); // load-use.
		add_row(itype_word(OP_BEQ, 1, 1, 1), 1'b0, 0, 32'h0);
		add_row(itype_word(OP_ADDI, 0, 15, 99), 1'b0, 0, 32'h0); // skipped.
		add_row(itype_word(OP_BEQ, 1, 2, 1), 1'b0, 0, 32'h0);
		add_row(itype_word(OP_ADDI, 0, 16, 7), 1'b1, 16, 32'h0000_0007);
		add_row(jump_word(OP_JAL, 23), 1'b1, 31, 32'h0000_0054); // word 20, link 84.
		add_row(itype_word(OP_ADDI, 0, 17, 1), 1'b0, 0, 32'h0);
		add_row(itype_word(OP_ADDI, 0, 18, 2), 1'b0, 0, 32'h0);
		add_row(rtype_word(1, 1, 0, FN_ADD), 1'b1, 0, 32'h0000_000a);
		add_row(rtype_word(31, 0, 20, FN_OR), 1'b1, 20, 32'h0000_0054);
		add_row(rtype_word(0, 20, 19, FN_ADD), 1'b1, 19, 32'h0000_0054); // r0 read late.
		add_row(itype_word(OP_BEQ, 0, 0, -1), 1'b0, 0, 32'h0); // park here.
	endtask

	task automatic load_program();
		for (int i = 0; i < row_count; i++) begin
			@(negedge clock);
			imem_write = 1'b1;
			imem_addr  = i[`CORE_IMEM_AW-1:0];
			imem_data  = prog_instr[i];
			exp_push   = prog_has_wb[i];
			exp_addr   = prog_wb_reg[i];
			exp_data   = prog_wb_val[i];
		end
		@(negedge clock);
		imem_write = 1'b0;
		exp_push   = 1'b0;
	endtask

	initial begin
		reset      = 1'b1;
		run        = 1'b0;
		imem_write = 1'b0;
		imem_addr  = '0;
		imem_data  = '0;
		exp_push   = 1'b0;
		exp_addr   = '0;
		exp_data   = '0;
		timed_out  = 1'b0;
		build_program();
		repeat (4) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		load_program();
		@(negedge clock);
		run = 1'b1;

		cycles = 0;
		while (seen_count < wb_expected && cycles < RUN_TIMEOUT) begin
			@(negedge clock);
			cycles++;
		end
		if (seen_count < wb_expected) begin
			timed_out = 1'b1;
			$display("timed out after %0d cycles with %0d of %0d write-backs seen",
				cycles, seen_count, wb_expected);
		end else begin
			cycles = 0; // any write-back from here on is extra.
			while (cycles < QUIET_CYCLES) begin
				@(negedge clock);
				cycles++;
			end
		end

		missing_count = (seen_count < wb_expected) ? wb_expected - seen_count : 0;
		$display("errors: %0d mismatched, %0d missing, %0d extra",
			mismatch_count, missing_count, extra_count);
		if (mismatch_count == 0 && missing_count == 0 && extra_count == 0 && !timed_out) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: core_top.f
+incdir+hdl
hdl/core_pkg.sv
hdl/decode_ctrl_if.sv
hdl/fetch_unit.sv
hdl/instr_decoder.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/interlock_unit.sv
hdl/regwalls.sv
hdl/data_mem.sv
hdl/core_top.sv
verif/wb_checker.sv
verif/core_top_tb.sv
